/* vlog.f */
common/cpuPkg.sv
common/ctrlIf.sv
source/control.sv
source/regFile.sv
source/alu.sv
source/pcUnit.sv
source/writeBack.sv
source/cpuTop.sv
testbench/cpuTb.sv

/* run.sh */
#!/bin/sh
# Build and run the cpuTb simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module cpuTb -o cpuSim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/cpuSim > sim.log 2>&1 ; cat sim.log

grep -qx "No errors" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* testbench/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;

    localparam cpuPkg::dataWordT ResetPc = 16'h0020;

    logic             clk;
    logic             rstN;
    cpuPkg::dataWordT instrAddr;
    cpuPkg::dataWordT instr;
    cpuPkg::dataWordT dataAddr;
    cpuPkg::dataWordT dataWrData;
    logic             dataRe;
    logic             dataWe;
    cpuPkg::dataWordT dataRdData;
    logic             halted;

    cpuPkg::dataWordT prog [128];
    cpuPkg::dataWordT dmem [1024];
    cpuPkg::dataWordT expAddr [$];
    cpuPkg::dataWordT expData [$];
    cpuPkg::dataWordT expLoad [$];
    int               progLen = 0;
    int               storeIdx = 0;
    int               loadIdx = 0;
    int               tests = 0;
    int               errors = 0;
    int               cycles = 0;

    cpuTop #(.resetPc(ResetPc)) i_cpuTop (
        .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr), .dataAddr(dataAddr),
        .dataWrData(dataWrData), .dataRe(dataRe), .dataWe(dataWe), .dataRdData(dataRdData),
        .halted(halted));

    function automatic cpuPkg::dataWordT encR(cpuPkg::aluOpT op, cpuPkg::regIdxT d,
                                              cpuPkg::regIdxT s, cpuPkg::regIdxT t);
        return {1'b0, op, d, s, t};
    endfunction

    function automatic cpuPkg::dataWordT encM(cpuPkg::opcodeT op, cpuPkg::regIdxT d,
                                              cpuPkg::regIdxT s, logic [3:0] off);
        return {op, d, s, off};
    endfunction

    function automatic cpuPkg::dataWordT encI(cpuPkg::opcodeT op, cpuPkg::regIdxT d,
                                              logic [7:0] b);
        return {op, d, b};
    endfunction

    // Reference results of the ALU group, shift amount fixed at 4
    function automatic cpuPkg::dataWordT aluModel(cpuPkg::aluOpT op, cpuPkg::dataWordT a,
                                                  cpuPkg::dataWordT b);
        case (op)
            cpuPkg::AluAdd: return a + b;
            cpuPkg::AluSub: return a - b;
            cpuPkg::AluXor: return a ^ b;
            cpuPkg::AluAnd: return a & b;
            cpuPkg::AluSll: return {a[11:0], 4'h0};
            cpuPkg::AluSra: return {{4{a[15]}}, a[15:4]};
            cpuPkg::AluRor: return {a[3:0], a[15:4]};
            default:        return a | b;
        endcase
    endfunction

    task automatic emit(input cpuPkg::dataWordT w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic expectStore(input cpuPkg::dataWordT a, input cpuPkg::dataWordT d);
        expAddr.push_back(a);
        expData.push_back(d);
    endtask

    task automatic expectLoad(input cpuPkg::dataWordT a);
        expLoad.push_back(a);
    endtask

    // Marker in r8 shows whether the skipped LLB ran
    task automatic branchTest(input cpuPkg::condT c, input bit taken, input logic [7:0] tag,
                              input logic [3:0] slot);
        emit(encI(cpuPkg::OpLlb, 4'd8, tag));
        emit({cpuPkg::OpBranch, c, 9'd1});
        emit(encI(cpuPkg::OpLlb, 4'd8, tag | 8'h80));
        emit(encM(cpuPkg::OpStore, 4'd8, 4'd10, slot));
        expectStore(16'h0200 + {11'd0, slot, 1'b0}, taken ? {8'h00, tag} : {8'h00, tag | 8'h80});
    endtask

    task automatic buildProgram();
        cpuPkg::dataWordT a;
        cpuPkg::dataWordT b;
        cpuPkg::aluOpT    op;
        int               nBr;
        a = 16'h9234;
        b = 16'h700F;
        emit(encI(cpuPkg::OpLlb, 4'd1, 8'h00));
        emit(encI(cpuPkg::OpLhb, 4'd1, 8'h01));      // r1 = 0x0100
        emit(encI(cpuPkg::OpLlb, 4'd2, a[7:0]));
        emit(encI(cpuPkg::OpLhb, 4'd2, a[15:8]));
        emit(encI(cpuPkg::OpLlb, 4'd3, b[7:0]));
        emit(encI(cpuPkg::OpLhb, 4'd3, b[15:8]));
        emit(encI(cpuPkg::OpLhb, 4'd10, 8'h02));     // Branch results base
        emit(encI(cpuPkg::OpLhb, 4'd13, 8'h03));
        for (int k = 0; k < 8; k++) begin
            op = cpuPkg::aluOpT'(k);
            emit(encR(op, 4'd4, 4'd2, (k >= 4 && k <= 6) ? 4'd4 : 4'd3));
            emit(encM(cpuPkg::OpStore, 4'd4, 4'd1, 4'(k)));
            expectStore(16'h0100 + 16'(2 * k), aluModel(op, a, b));
        end
        emit(encM(cpuPkg::OpLoad, 4'd6, 4'd1, 4'd7));
        expectLoad(16'h010E);
        emit(encM(cpuPkg::OpStore, 4'd6, 4'd1, 4'd8));   // Offset -8
        expectStore(16'h00F0, a | b);
        emit(encM(cpuPkg::OpLoad, 4'd7, 4'd1, 4'd8));
        expectLoad(16'h00F0);
        emit(encM(cpuPkg::OpStore, 4'd7, 4'd1, 4'd15));  // Offset -1
        expectStore(16'h00FE, a | b);
        emit(encR(cpuPkg::AluSub, 4'd4, 4'd3, 4'd3));     // Z
        branchTest(cpuPkg::CondEq, 1'b1, 8'h10, 4'd0);
        branchTest(cpuPkg::CondNe, 1'b0, 8'h11, 4'd1);
        branchTest(cpuPkg::CondLe, 1'b1, 8'h12, 4'd2);
        branchTest(cpuPkg::CondGt, 1'b0, 8'h13, 4'd3);
        emit(encR(cpuPkg::AluAdd, 4'd4, 4'd2, 4'd2));     // V without N
        branchTest(cpuPkg::CondOv, 1'b1, 8'h14, 4'd4);
        branchTest(cpuPkg::CondGe, 1'b1, 8'h15, 4'd5);
        emit(encR(cpuPkg::AluAdd, 4'd4, 4'd2, 4'd0));     // N only
        branchTest(cpuPkg::CondLt, 1'b1, 8'h16, 4'd6);
        branchTest(cpuPkg::CondAlways, 1'b1, 8'h17, 4'd7);
        nBr = progLen;
        emit(encI(cpuPkg::OpLlb, 4'd11, 8'(ResetPc + 16'(2 * (nBr + 3)))));
        emit({cpuPkg::OpBranchReg, cpuPkg::CondAlways, 1'b0, 4'd11, 4'd0});
        emit(encI(cpuPkg::OpLlb, 4'd8, 8'hEE));          // Skipped by BR
        emit(encI(cpuPkg::OpPcs, 4'd12, 8'h00));
        emit(encM(cpuPkg::OpStore, 4'd12, 4'd13, 4'd0));
        expectStore(16'h0300, ResetPc + 16'(2 * (nBr + 4)));
        emit(encM(cpuPkg::OpStore, 4'd8, 4'd13, 4'd1));
        expectStore(16'h0302, 16'h0017);
        emit(encR(cpuPkg::AluAdd, 4'd0, 4'd2, 4'd3));
        emit(encI(cpuPkg::OpLlb, 4'd0, 8'h55));
        emit(encM(cpuPkg::OpStore, 4'd0, 4'd13, 4'd2));
        expectStore(16'h0304, 16'h0000);
        emit({cpuPkg::OpHalt, 12'h000});
        emit(encM(cpuPkg::OpStore, 4'd2, 4'd13, 4'd3));  // Must never commit
    endtask

    function automatic cpuPkg::dataWordT fetch(cpuPkg::dataWordT addr);
        cpuPkg::dataWordT idx;
        idx = (addr - ResetPc) >> 1;
        if (idx < 16'(progLen)) begin
            return prog[idx[6:0]];
        end
        return {cpuPkg::OpHalt, 12'h000};
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Inputs follow each rising edge by a fixed delay
    initial begin
        forever begin
            @(posedge clk);
            #1 instr = fetch(instrAddr);
            #1 dataRdData = dmem[dataAddr[10:1]];
        end
    end

    always @(negedge clk) begin
        int errBefore;
        if (rstN && dataRe) begin
            errBefore = errors;
            if (loadIdx >= expLoad.size()) begin
                $display("Unexpected load from address %h after the last expected one",
                         dataAddr);
                errors++;
            end else begin
                assert (dataAddr == expLoad[loadIdx]) else begin
                    $display("[ERROR] dataAddr: got %h, expected %h", dataAddr,
                             expLoad[loadIdx]);
                    errors++;
                end
            end
            tests++;
            $display("Test load %0d: %s", loadIdx, (errors == errBefore) ? "ok" : "failed");
            loadIdx++;
        end
        if (rstN && dataWe) begin
            errBefore = errors;
            if (storeIdx >= expAddr.size()) begin
                $display("Unexpected store to address %h after the last expected one", dataAddr);
                errors++;
            end else begin
                assert (dataAddr == expAddr[storeIdx]) else begin
                    $display("[ERROR] dataAddr: got %h, expected %h", dataAddr, expAddr[storeIdx]);
                    errors++;
                end
                assert (dataWrData == expData[storeIdx]) else begin
                    $display("[ERROR] dataWrData: got %h, expected %h", dataWrData,
                             expData[storeIdx]);
                    errors++;
                end
            end
            tests++;
            $display("Test store %0d: %s", storeIdx, (errors == errBefore) ? "ok" : "failed");
            storeIdx++;
            dmem[dataAddr[10:1]] = dataWrData;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (progLen > 0 && cycles > 2 * progLen + 50) begin
            $display("Timeout: run did not finish within %0d cycles", cycles - 1);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        int               errBefore;
        cpuPkg::dataWordT haltPc;
        rstN = 1'b0;
        instr = '0;
        dataRdData = '0;
        buildProgram();
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = 16'h5A5A ^ 16'(i * 263);
        end
        repeat (9) @(posedge clk);
        @(negedge clk);
        errBefore = errors;
        assert (instrAddr == ResetPc) else begin
            $display("[ERROR] instrAddr: got %h, expected %h", instrAddr, ResetPc);
            errors++;
        end
        assert (!dataWe && !halted) else begin
            $display("[ERROR] dataWe/halted: got %h/%h, expected 0/0", dataWe, halted);
            errors++;
        end
        tests++;
        $display("Test reset: %s", (errors == errBefore) ? "ok" : "failed");
        @(posedge clk);
        #1 rstN = 1'b1;
        while (!halted) begin
            @(posedge clk);
            #3;
        end
        haltPc = instrAddr;
        errBefore = errors;
        repeat (10) begin
            @(posedge clk);
            #3;
            assert (halted) else begin
                $display("[ERROR] halted: got %h, expected 1", halted);
                errors++;
            end
            assert (instrAddr == haltPc) else begin
                $display("[ERROR] instrAddr: got %h, expected %h", instrAddr, haltPc);
                errors++;
            end
        end
        assert (storeIdx == expAddr.size()) else begin
            $display("Only %0d of %0d expected stores were seen", storeIdx, expAddr.size());
            errors++;
        end
        assert (loadIdx == expLoad.size()) else begin
            $display("Only %0d of %0d expected loads were seen", loadIdx, expLoad.size());
            errors++;
        end
        tests++;
        $display("Test halt: %s", (errors == errBefore) ? "ok" : "failed");
        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* source/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop #(
    parameter cpuPkg::dataWordT resetPc = 16'h0000
) (
    input  logic             clk,
    input  logic             rstN,
    output cpuPkg::dataWordT instrAddr,
    input  cpuPkg::dataWordT instr,
    output cpuPkg::dataWordT dataAddr,
    output cpuPkg::dataWordT dataWrData,
    output logic             dataRe,
    output logic             dataWe,
    input  cpuPkg::dataWordT dataRdData,
    output logic             halted
);

    cpuPkg::opcodeT   opcode;
    cpuPkg::regIdxT   rd;
    cpuPkg::regIdxT   rs;
    cpuPkg::regIdxT   rt;
    cpuPkg::regIdxT   rdAddrB;
    logic             readsRd;
    cpuPkg::dataWordT rdDataA;
    cpuPkg::dataWordT rdDataB;
    cpuPkg::dataWordT aluResult;
    cpuPkg::flagsT    flags;
    cpuPkg::dataWordT pcNext2;
    cpuPkg::dataWordT wrData;
    logic             retire;

    ctrlIf ctrlBus ();

    assign opcode = instr[15:12];
    assign rd     = instr[11:8];
    assign rs     = instr[7:4];
    assign rt     = instr[3:0];

    // SW, LLB and LHB need the current rd value
    assign readsRd = (opcode == cpuPkg::OpStore) || (opcode == cpuPkg::OpLlb) ||
                     (opcode == cpuPkg::OpLhb);
    assign rdAddrB = readsRd ? rd : rt;

    control i_control (.opcode(opcode), .funct(instr[14:12]), .ctrl(ctrlBus.decoder));

    regFile i_regFile (.clk(clk), .rstN(rstN), .rdAddrA(rs), .rdAddrB(rdAddrB),
                       .rdDataA(rdDataA), .rdDataB(rdDataB),
                       .wrEn(ctrlBus.regWrite & retire), .wrAddr(rd), .wrData(wrData));

    alu i_alu (.clk(clk), .rstN(rstN), .ctrl(ctrlBus.exec), .srcA(rdDataA), .srcB(rdDataB),
               .imm(rt), .result(aluResult), .flags(flags), .retire(retire));

    pcUnit #(.resetPc(resetPc)) i_pcUnit (
        .clk(clk), .rstN(rstN), .ctrl(ctrlBus.pc), .cond(instr[11:9]),
        .offset(instr[8:0]), .target(rdDataA), .flags(flags), .pc(instrAddr),
        .pcNext2(pcNext2), .halted(halted), .retire(retire));

    writeBack i_writeBack (.ctrl(ctrlBus.result), .aluResult(aluResult), .memData(dataRdData),
                           .rdOld(rdDataB), .pcNext2(pcNext2), .byteImm(instr[7:0]),
                           .wrData(wrData));

    assign dataAddr   = aluResult;
    assign dataWrData = rdDataB;
    assign dataRe     = ctrlBus.memRead;
    assign dataWe     = ctrlBus.memWrite & retire;   // No stores once halted

endmodule

/* source/writeBack.sv */
`timescale 1ns/1ps

module writeBack (
    ctrlIf.result            ctrl,
    input  cpuPkg::dataWordT aluResult,
    input  cpuPkg::dataWordT memData,
    input  cpuPkg::dataWordT rdOld,
    input  cpuPkg::dataWordT pcNext2,
    input  logic [7:0]       byteImm,
    output cpuPkg::dataWordT wrData
);

    cpuPkg::dataWordT byteMerged;

    // LHB keeps the low byte, LLB keeps the high byte
    assign byteMerged = ctrl.memHalf ? {byteImm, rdOld[7:0]}
                                     : {rdOld[15:8], byteImm};

    always_comb begin
        if (ctrl.memToReg) begin
            wrData = memData;
        end else if (ctrl.pcSave) begin
            wrData = pcNext2;
        end else if (!ctrl.regDst) begin
            wrData = byteMerged;             // LLB or LHB
        end else begin
            wrData = aluResult;
        end
    end

endmodule

/* source/pcUnit.sv */
`timescale 1ns/1ps

module pcUnit #(
    parameter cpuPkg::dataWordT resetPc = 16'h0000
) (
    input  logic             clk,
    input  logic             rstN,
    ctrlIf.pc                ctrl,
    input  cpuPkg::condT     cond,
    input  logic [8:0]       offset,
    input  cpuPkg::dataWordT target,
    input  cpuPkg::flagsT    flags,
    output cpuPkg::dataWordT pc,
    output cpuPkg::dataWordT pcNext2,
    output logic             halted,
    output logic             retire
);

    logic             zf;
    logic             vf;
    logic             nf;
    logic             condMet;
    cpuPkg::dataWordT relTarget;
    cpuPkg::dataWordT pcNext;

    assign zf = flags[cpuPkg::FlagZ];
    assign vf = flags[cpuPkg::FlagV];
    assign nf = flags[cpuPkg::FlagN];

    always_comb begin
        case (cond)
            cpuPkg::CondNe: condMet = ~zf;
            cpuPkg::CondEq: condMet = zf;
            cpuPkg::CondGt: condMet = ~zf & ~nf;
            cpuPkg::CondLt: condMet = nf;
            cpuPkg::CondGe: condMet = ~nf;
            cpuPkg::CondLe: condMet = zf | nf;
            cpuPkg::CondOv: condMet = vf;
            default:        condMet = 1'b1;
        endcase
    end

    assign pcNext2   = pc + 16'd2;
    assign relTarget = pcNext2 + {{6{offset[8]}}, offset, 1'b0};

    always_comb begin
        pcNext = pcNext2;
        if (halted || ctrl.halt) begin
            pcNext = pc;                     // Hold on HLT
        end else if (ctrl.branch && condMet) begin
            pcNext = ctrl.branchReg ? target : relTarget;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc     <= resetPc;
            halted <= 1'b0;
        end else begin
            pc <= pcNext;
            if (ctrl.halt) begin
                halted <= 1'b1;              // Sticky until reset
            end
        end
    end

    assign retire = ~halted;

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic             clk,
    input  logic             rstN,
    ctrlIf.exec              ctrl,
    input  cpuPkg::dataWordT srcA,
    input  cpuPkg::dataWordT srcB,
    input  cpuPkg::regIdxT   imm,
    output cpuPkg::dataWordT result,
    output cpuPkg::flagsT    flags,
    input  logic             retire
);

    cpuPkg::dataWordT immOff;
    cpuPkg::dataWordT opB;
    cpuPkg::dataWordT aluOut;
    cpuPkg::dataWordT sraOut;
    logic [31:0]      rotWide;
    logic             addOvf;
    logic             subOvf;
    logic             isAluInstr;
    cpuPkg::flagsT    flagsQ;

    assign immOff = {{11{imm[3]}}, imm, 1'b0};   // Word offset in bytes
    assign opB    = ctrl.aluSrc ? srcB : immOff;

    assign sraOut  = $signed(srcA) >>> imm;
    assign rotWide = {srcA, srcA} >> imm;

    always_comb begin
        case (ctrl.aluOp)
            cpuPkg::AluAdd: aluOut = srcA + opB;
            cpuPkg::AluSub: aluOut = srcA - opB;
            cpuPkg::AluXor: aluOut = srcA ^ opB;
            cpuPkg::AluAnd: aluOut = srcA & opB;
            cpuPkg::AluSll: aluOut = srcA << imm;
            cpuPkg::AluSra: aluOut = sraOut;
            cpuPkg::AluRor: aluOut = rotWide[15:0];
            default:        aluOut = srcA | opB;
        endcase
    end

    assign addOvf = (srcA[15] == opB[15]) && (aluOut[15] != srcA[15]);
    assign subOvf = (srcA[15] != opB[15]) && (aluOut[15] != srcA[15]);

    // Loads and stores also use the adder but leave flags alone
    assign isAluInstr = ctrl.aluSrc & ~(ctrl.memRead | ctrl.memWrite);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flagsQ <= '0;
        end else if (retire && isAluInstr) begin
            flagsQ[cpuPkg::FlagZ] <= (aluOut == '0);
            if (ctrl.aluOp == cpuPkg::AluAdd) begin
                flagsQ[cpuPkg::FlagV] <= addOvf;
                flagsQ[cpuPkg::FlagN] <= aluOut[15];
            end else if (ctrl.aluOp == cpuPkg::AluSub) begin
                flagsQ[cpuPkg::FlagV] <= subOvf;
                flagsQ[cpuPkg::FlagN] <= aluOut[15];
            end
        end
    end

    assign result = aluOut;
    assign flags  = flagsQ;

endmodule

/* source/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic             clk,
    input  logic             rstN,
    input  cpuPkg::regIdxT   rdAddrA,
    input  cpuPkg::regIdxT   rdAddrB,
    output cpuPkg::dataWordT rdDataA,
    output cpuPkg::dataWordT rdDataB,
    input  logic             wrEn,
    input  cpuPkg::regIdxT   wrAddr,
    input  cpuPkg::dataWordT wrData
);

    cpuPkg::dataWordT regs [16];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // r0 is hardwired to zero
    assign rdDataA = (rdAddrA == 4'd0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == 4'd0) ? '0 : regs[rdAddrB];

endmodule

/* source/control.sv */
`timescale 1ns/1ps

module control (
    input  cpuPkg::opcodeT opcode,
    input  cpuPkg::aluOpT  funct,
    ctrlIf.decoder         ctrl
);

    always_comb begin
        ctrl.regDst    = 1'b0;
        ctrl.branch    = 1'b0;
        ctrl.branchReg = 1'b0;
        ctrl.memRead   = 1'b0;
        ctrl.memToReg  = 1'b0;
        ctrl.aluSrc    = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.memHalf   = 1'b0;
        ctrl.regWrite  = 1'b0;
        ctrl.pcSave    = 1'b0;
        ctrl.halt      = 1'b0;
        ctrl.aluOp     = cpuPkg::AluAdd;     // Address adder by default

        casez (opcode)
            4'b0???: begin                   // Register ALU ops
                ctrl.regDst   = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = funct;
            end
            cpuPkg::OpLoad: begin
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = cpuPkg::AluAdd;
            end
            cpuPkg::OpStore: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = cpuPkg::AluAdd;
            end
            cpuPkg::OpLlb: begin
                ctrl.regWrite = 1'b1;        // Low byte merge
            end
            cpuPkg::OpLhb: begin
                ctrl.memHalf  = 1'b1;        // High byte merge
                ctrl.regWrite = 1'b1;
            end
            cpuPkg::OpBranch: begin
                ctrl.branch = 1'b1;
            end
            cpuPkg::OpBranchReg: begin
                ctrl.branch    = 1'b1;
                ctrl.branchReg = 1'b1;
            end
            cpuPkg::OpPcs: begin
                // rd takes the return address
                ctrl.pcSave   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            cpuPkg::OpHalt: begin
                ctrl.halt = 1'b1;
            end
            default: begin
                ctrl.halt = 1'b0;
            end
        endcase
    end

endmodule

/* common/ctrlIf.sv */
`timescale 1ns/1ps

interface ctrlIf;

    logic          regDst;
    logic          branch;
    logic          branchReg;
    logic          memRead;
    logic          memToReg;
    logic          aluSrc;
    logic          memWrite;
    logic          memHalf;
    logic          regWrite;
    logic          pcSave;
    logic          halt;
    cpuPkg::aluOpT aluOp;

    modport decoder (output regDst, branch, branchReg, memRead, memToReg, aluSrc,
                     memWrite, memHalf, regWrite, pcSave, halt, aluOp);

    modport exec (input aluSrc, aluOp, memRead, memWrite, regWrite);

    modport result (input regDst, memToReg, memHalf, pcSave);

    modport pc (input branch, branchReg, halt);

endinterface

/* common/cpuPkg.sv */
package cpuPkg;

    typedef logic [15:0] dataWordT;
    typedef logic [3:0]  regIdxT;
    typedef logic [3:0]  opcodeT;
    typedef logic [2:0]  aluOpT;
    typedef logic [2:0]  condT;
    typedef logic [2:0]  flagsT;     // {Z, V, N}

    localparam int FlagZ = 2;
    localparam int FlagV = 1;
    localparam int FlagN = 0;

    // Opcodes with bit 15 set; 0xxx is the ALU group
    localparam opcodeT OpLoad      = 4'b1000;
    localparam opcodeT OpStore     = 4'b1001;
    localparam opcodeT OpLlb       = 4'b1010;
    localparam opcodeT OpLhb       = 4'b1011;
    localparam opcodeT OpBranch    = 4'b1100;
    localparam opcodeT OpBranchReg = 4'b1101;
    localparam opcodeT OpPcs       = 4'b1110;
    localparam opcodeT OpHalt      = 4'b1111;

    localparam aluOpT AluAdd = 3'b000;
    localparam aluOpT AluSub = 3'b001;
    localparam aluOpT AluXor = 3'b010;
    localparam aluOpT AluAnd = 3'b011;
    localparam aluOpT AluSll = 3'b100;
    localparam aluOpT AluSra = 3'b101;
    localparam aluOpT AluRor = 3'b110;
    localparam aluOpT AluOr  = 3'b111;

    localparam condT CondNe     = 3'b000;
    localparam condT CondEq     = 3'b001;
    localparam condT CondGt     = 3'b010;
    localparam condT CondLt     = 3'b011;
    localparam condT CondGe     = 3'b100;
    localparam condT CondLe     = 3'b101;
    localparam condT CondOv     = 3'b110;
    localparam condT CondAlways = 3'b111;

endpackage
